// File: design/stb_geom_pkg.sv
//--------------------------------------------------------------------------
// Geometry of the store buffer: widths of one store and the queue depth
// One slot always stays free, so STB_DEPTH-1 stores fit at once
// STB_DEPTH is expected to be a power of two of at least 2
//--------------------------------------------------------------------------

package stb_geom_pkg;

    // One store as presented by the LSU
    localparam int STB_ADDR_W = 32;    // Byte address
    localparam int STB_DATA_W = 32;    // One data word
    localparam int STB_SEL_W  = 4;     // Byte lane selects

    // Circular queue
    localparam int STB_DEPTH  = 4;     // Slots, not usable entries
    localparam int STB_IDX_W  = $clog2(STB_DEPTH);

endpackage

// File: design/stb_ctrl_pkg.sv
//--------------------------------------------------------------------------
// Control constants of the store buffer drain logic
// State codes are plain localparams of ST_W bits
// ACK_TIMEOUT counts cycles of one cache request before a reissue
// TMR_W must be able to hold ACK_TIMEOUT-1
//--------------------------------------------------------------------------

package stb_ctrl_pkg;

    // Drain FSM encoding
    localparam int ST_W = 2;
    localparam logic [ST_W-1:0] ST_IDLE   = 2'd0;  // Nothing on the cache port
    localparam logic [ST_W-1:0] ST_BYPASS = 2'd1;  // LSU word straight to cache
    localparam logic [ST_W-1:0] ST_ISSUE  = 2'd2;  // Head entry on the cache port
    localparam logic [ST_W-1:0] ST_RETRY  = 2'd3;  // One dead cycle after timeout

    // Acknowledge watchdog
    localparam int ACK_TIMEOUT = 16;   // Cycles per request attempt
    localparam int TMR_W       = 5;

endpackage

// File: design/stb_datapath.sv
//--------------------------------------------------------------------------
// Store buffer storage: circular queue of STB_DEPTH slots
// Full when the write index is one behind the read index, so one slot
// is never used. Writes and pops are not checked against full/empty,
// the FSM must only strobe them when legal
// Cache outputs read zero when neither bypass nor rd_sel is active
//--------------------------------------------------------------------------

module stb_datapath
    import stb_geom_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    // Store from the LSU
    input  logic [STB_ADDR_W-1:0] lsu_addr,
    input  logic [STB_DATA_W-1:0] lsu_wdata,
    input  logic [STB_SEL_W-1:0]  lsu_sel,

    // Strobes from the drain FSM
    input  logic                  stb_wr_en,    // Push at write index
    input  logic                  stb_rd_en,    // Pop the head
    input  logic                  rd_sel,       // Head entry onto cache port
    input  logic                  stb_bypass,   // LSU word onto cache port

    // Cache request payload
    output logic [STB_ADDR_W-1:0] dcache_addr,
    output logic [STB_DATA_W-1:0] dcache_wdata,
    output logic [STB_SEL_W-1:0]  dcache_sel,

    // Queue status
    output logic                  stb_full,
    output logic                  stb_empty
);

    // Slot storage, no reset needed
    logic [STB_ADDR_W-1:0] addr_q [STB_DEPTH];
    logic [STB_DATA_W-1:0] data_q [STB_DEPTH];
    logic [STB_SEL_W-1:0]  sel_q  [STB_DEPTH];

    logic [STB_IDX_W-1:0]  wr_idx;
    logic [STB_IDX_W-1:0]  rd_idx;
    logic [STB_IDX_W-1:0]  wr_idx_nxt;   // Write index plus one, wrapped
    logic [STB_IDX_W-1:0]  rd_idx_nxt;

    localparam logic [STB_IDX_W-1:0] LAST_IDX = STB_IDX_W'(STB_DEPTH - 1);

    assign wr_idx_nxt = (wr_idx == LAST_IDX) ? '0 : wr_idx + 1'b1;
    assign rd_idx_nxt = (rd_idx == LAST_IDX) ? '0 : rd_idx + 1'b1;

    // Write index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_idx <= '0;
        end else if (stb_wr_en) begin
            wr_idx <= wr_idx_nxt;
        end
    end

    // Read index, moves on cache acknowledge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_idx <= '0;
        end else if (stb_rd_en) begin
            rd_idx <= rd_idx_nxt;
        end
    end

    // Entry lands on the accept edge
    always_ff @(posedge clk) begin
        if (stb_wr_en) begin
            addr_q[wr_idx] <= lsu_addr;
            data_q[wr_idx] <= lsu_wdata;
            sel_q[wr_idx]  <= lsu_sel;
        end
    end

    // Cache port mux, bypass has priority
    always_comb begin
        if (stb_bypass) begin
            dcache_addr  = lsu_addr;
            dcache_wdata = lsu_wdata;
            dcache_sel   = lsu_sel;
        end else if (rd_sel) begin
            dcache_addr  = addr_q[rd_idx];   // Head entry
            dcache_wdata = data_q[rd_idx];
            dcache_sel   = sel_q[rd_idx];
        end else begin
            dcache_addr  = '0;
            dcache_wdata = '0;
            dcache_sel   = '0;
        end
    end

    // Status flags
    assign stb_full  = (wr_idx_nxt == rd_idx);
    assign stb_empty = (wr_idx == rd_idx);

endmodule

// File: design/stb_ack_timer.sv
//--------------------------------------------------------------------------
// Acknowledge watchdog for one cache request
// Counts cycles while tmr_run is high, clears as soon as it drops
// tmr_expired is high in the ACK_TIMEOUT-th cycle of a request, and
// stays high while tmr_run is held beyond that
//--------------------------------------------------------------------------

module stb_ack_timer
    import stb_ctrl_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic tmr_run,       // Request outstanding
    output logic tmr_expired
);

    localparam logic [TMR_W-1:0] LIMIT = TMR_W'(ACK_TIMEOUT - 1);

    logic [TMR_W-1:0] cnt;
    logic             at_limit;

    assign at_limit = (cnt == LIMIT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!tmr_run) begin
            cnt <= '0;                 // Fresh count per attempt
        end else if (!at_limit) begin
            cnt <= cnt + 1'b1;         // Saturates at the limit
        end
    end

    assign tmr_expired = tmr_run && at_limit;

endmodule

// File: design/stb_drain_fsm.sv
//--------------------------------------------------------------------------
// Drain FSM of the store buffer
// Accepts LSU stores into the queue, or bypasses one straight to the
// cache when the queue is empty and idle. Issues the head entry, pops it
// on dcache_ack, and after a timer expiry drops dcache_req for exactly
// one ST_RETRY cycle before reissuing the same request
// lsu_st_ack is combinational from lsu_st_req and dcache_ack
//--------------------------------------------------------------------------

module stb_drain_fsm
    import stb_ctrl_pkg::*;
(
    input  logic clk,
    input  logic rst_n,

    // LSU handshake
    input  logic lsu_st_req,     // Level, held until ack
    output logic lsu_st_ack,     // One-cycle pulse

    // Cache handshake
    input  logic dcache_ack,     // One-cycle pulse
    output logic dcache_req,     // Level until ack or timeout

    // Datapath control and status
    input  logic stb_full,
    input  logic stb_empty,
    output logic stb_wr_en,
    output logic stb_rd_en,
    output logic rd_sel,
    output logic stb_bypass,

    // Acknowledge timer
    input  logic tmr_expired,
    output logic tmr_run,
    output logic stb_timeout
);

    logic [ST_W-1:0] state;
    logic [ST_W-1:0] state_nxt;
    logic            retry_byp;   // Retry belongs to a bypassed store
    logic            waiting;     // Cache request outstanding
    logic            byp_start;
    logic            byp_hold;    // LSU word owned by the bypass path
    logic            give_up;

    assign waiting   = (state == ST_ISSUE) || (state == ST_BYPASS);
    assign byp_start = (state == ST_IDLE) && stb_empty && lsu_st_req;

    // Also covers the retry gap of a bypass, else the held word
    // would be queued a second time
    assign byp_hold  = (state == ST_BYPASS) || ((state == ST_RETRY) && retry_byp);

    assign give_up   = waiting && tmr_expired && !dcache_ack;  // Ack wins a tie

    // Queue accept, entry lands at this edge
    assign stb_wr_en  = lsu_st_req && !stb_full && !byp_start && !byp_hold;
    assign stb_rd_en  = (state == ST_ISSUE) && dcache_ack;     // Pop the head

    assign rd_sel     = (state == ST_ISSUE);
    assign stb_bypass = (state == ST_BYPASS);
    assign dcache_req = waiting;   // Low in ST_RETRY
    assign tmr_run    = waiting;
    assign stb_timeout = give_up;

    // Queued: ack on accept. Bypass: ack mirrors the cache
    assign lsu_st_ack = stb_wr_en || (stb_bypass && dcache_ack);

    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (byp_start) begin
                    state_nxt = ST_BYPASS;
                end else if (!stb_empty) begin
                    state_nxt = ST_ISSUE;          // Registered flag, one cycle late
                end
            end
            ST_BYPASS, ST_ISSUE: begin
                if (dcache_ack) begin
                    state_nxt = ST_IDLE;
                end else if (give_up) begin
                    state_nxt = ST_RETRY;
                end
            end
            ST_RETRY: begin
                state_nxt = retry_byp ? ST_BYPASS : ST_ISSUE;  // Same request again
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            retry_byp <= 1'b0;
        end else begin
            state <= state_nxt;
            if (give_up) begin
                retry_byp <= (state == ST_BYPASS);  // Remember what to reissue
            end
        end
    end

endmodule

// File: design/store_buffer_top.sv
//--------------------------------------------------------------------------
// Store buffer top level
// LSU side: level request with address, data and byte selects, held
// until the one-cycle lsu_st_ack
// Cache side: level dcache_req, stable until the one-cycle dcache_ack
// No load forwarding and no store merging
//--------------------------------------------------------------------------

module store_buffer_top
    import stb_geom_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    // LSU store port
    input  logic                  lsu_st_req,
    input  logic [STB_ADDR_W-1:0] lsu_addr,
    input  logic [STB_DATA_W-1:0] lsu_wdata,
    input  logic [STB_SEL_W-1:0]  lsu_sel,
    output logic                  lsu_st_ack,

    // Data cache write port
    output logic                  dcache_req,
    output logic [STB_ADDR_W-1:0] dcache_addr,
    output logic [STB_DATA_W-1:0] dcache_wdata,
    output logic [STB_SEL_W-1:0]  dcache_sel,
    input  logic                  dcache_ack,

    // Status
    output logic                  stb_empty,
    output logic                  stb_timeout    // One-cycle pulse
);

    logic stb_wr_en;
    logic stb_rd_en;
    logic rd_sel;
    logic stb_bypass;
    logic stb_full;
    logic tmr_run;
    logic tmr_expired;

    stb_datapath u_datapath (
        .clk          (clk),
        .rst_n        (rst_n),
        .lsu_addr     (lsu_addr),
        .lsu_wdata    (lsu_wdata),
        .lsu_sel      (lsu_sel),
        .stb_wr_en    (stb_wr_en),
        .stb_rd_en    (stb_rd_en),
        .rd_sel       (rd_sel),
        .stb_bypass   (stb_bypass),
        .dcache_addr  (dcache_addr),
        .dcache_wdata (dcache_wdata),
        .dcache_sel   (dcache_sel),
        .stb_full     (stb_full),
        .stb_empty    (stb_empty)
    );

    stb_drain_fsm u_drain_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .lsu_st_req   (lsu_st_req),
        .lsu_st_ack   (lsu_st_ack),
        .dcache_ack   (dcache_ack),
        .dcache_req   (dcache_req),
        .stb_full     (stb_full),
        .stb_empty    (stb_empty),
        .stb_wr_en    (stb_wr_en),
        .stb_rd_en    (stb_rd_en),
        .rd_sel       (rd_sel),
        .stb_bypass   (stb_bypass),
        .tmr_expired  (tmr_expired),
        .tmr_run      (tmr_run),
        .stb_timeout  (stb_timeout)
    );

    // Watches every cache request, bypass or queued
    stb_ack_timer u_ack_timer (
        .clk          (clk),
        .rst_n        (rst_n),
        .tmr_run      (tmr_run),
        .tmr_expired  (tmr_expired)
    );

endmodule

// File: verif/store_buffer_assert.sv
//--------------------------------------------------------------------------
// Handshake rules of the store buffer top level, bound to every instance
// Payload stability excludes the timeout cycle, where the request drops
//--------------------------------------------------------------------------

module store_buffer_assert
    import stb_geom_pkg::*;
(
    input logic                  clk,
    input logic                  rst_n,
    input logic                  lsu_st_ack,
    input logic                  dcache_req,
    input logic                  dcache_ack,
    input logic [STB_ADDR_W-1:0] dcache_addr,
    input logic [STB_DATA_W-1:0] dcache_wdata,
    input logic [STB_SEL_W-1:0]  dcache_sel,
    input logic                  stb_timeout
);
    timeunit 1ns;
    timeprecision 100ps;

    // Pending request keeps its payload
    payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
        dcache_req && !dcache_ack && !stb_timeout |=>
            $stable(dcache_addr) && $stable(dcache_wdata) && $stable(dcache_sel))
        else $error("cache payload changed while request pending");

    lsu_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_st_ack |=> !lsu_st_ack)
        else $error("lsu_st_ack longer than one cycle");

    cache_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        dcache_ack |=> !dcache_ack)
        else $error("dcache_ack longer than one cycle");

    // One dead cycle, then the reissue
    retry_gap: assert property (@(posedge clk) disable iff (!rst_n)
        stb_timeout |=> !dcache_req ##1 dcache_req)
        else $error("no single idle cycle after stb_timeout");

endmodule

bind store_buffer_top store_buffer_assert u_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_st_ack   (lsu_st_ack),
    .dcache_req   (dcache_req),
    .dcache_ack   (dcache_ack),
    .dcache_addr  (dcache_addr),
    .dcache_wdata (dcache_wdata),
    .dcache_sel   (dcache_sel),
    .stb_timeout  (stb_timeout)
);

// File: verif/store_buffer_tb.sv
//--------------------------------------------------------------------------
// Store buffer testbench with a cache model acking after a tabled delay
// A single LSU port holds its request until lsu_st_ack, so every store
// into the idle buffer takes the bypass path and the queue stays empty
// Delays avoid the timeout boundary so ack never meets the retry cycle
//--------------------------------------------------------------------------

module store_buffer_tb
    import stb_geom_pkg::*, stb_ctrl_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_ST = 8;
    localparam int WAIT_MAX = 200;                    // Cycles per wait loop

    logic clk;
    logic rst_n;
    logic lsu_st_req;
    logic dcache_ack = 1'b0;                          // Low before the first edge
    logic [STB_ADDR_W-1:0] lsu_addr;
    logic [STB_DATA_W-1:0] lsu_wdata;
    logic [STB_SEL_W-1:0]  lsu_sel;
    logic lsu_st_ack;
    logic dcache_req;
    logic stb_empty;
    logic stb_timeout;
    logic [STB_ADDR_W-1:0] dcache_addr;
    logic [STB_DATA_W-1:0] dcache_wdata;
    logic [STB_SEL_W-1:0]  dcache_sel;

    // Stimulus table and expected results
    logic [STB_ADDR_W-1:0] tbl_addr [N_ST];
    logic [STB_DATA_W-1:0] tbl_data [N_ST];
    logic [STB_SEL_W-1:0]  tbl_sel  [N_ST];
    int tbl_delay [N_ST];

    logic [STB_ADDR_W-1:0] obs_addr [$];              // Writes seen by cache model
    logic [STB_DATA_W-1:0] obs_data [$];
    logic [STB_SEL_W-1:0]  obs_sel  [$];

    int val_errs = 0;
    int wait_errs = 0;
    int cur_delay = 0;                                // Handed to cache model
    int store_id = 0;
    int n_timeouts = 0;
    int exp_timeouts = 0;

    store_buffer_top uut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic report_fail(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        val_errs++;
    endtask

    task automatic check_addr(input logic [STB_ADDR_W-1:0] got, exp, input string what);
        if (got !== exp) report_fail($sformatf("%s addr %h, expected %h", what, got, exp));
    endtask

    task automatic check_word(input logic [STB_DATA_W-1:0] got, exp, input string what);
        if (got !== exp) report_fail($sformatf("%s data %h, expected %h", what, got, exp));
    endtask

    task automatic check_sel(input logic [STB_SEL_W-1:0] got, exp, input string what);
        if (got !== exp) report_fail($sformatf("%s sel %h, expected %h", what, got, exp));
    endtask

    task automatic check_flag(input logic got, exp, input string what);
        if (got !== exp) report_fail($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    // Cache model counts request-high cycles across retries
    int left = 0;
    int loaded_id = -1;
    always @(posedge clk) begin
        if (!rst_n) begin
            dcache_ack <= 1'b0;
            loaded_id = -1;
        end else begin
            dcache_ack <= 1'b0;
            if (dcache_req && dcache_ack) begin       // Write accepted
                obs_addr.push_back(dcache_addr);
                obs_data.push_back(dcache_wdata);
                obs_sel.push_back(dcache_sel);
            end else if (dcache_req) begin
                if (loaded_id != store_id) begin      // New store
                    left = cur_delay;
                    loaded_id = store_id;
                end
                if (left == 0) begin
                    dcache_ack <= 1'b1;
                end else begin
                    left = left - 1;
                end
            end
        end
    end

    // Timeout monitor expects one idle cycle then the same payload
    int rphase = 0;
    logic [STB_ADDR_W-1:0] to_addr;
    logic [STB_DATA_W-1:0] to_data;
    logic [STB_SEL_W-1:0]  to_sel;
    always @(posedge clk) begin
        if (rst_n && rphase == 1) begin
            check_flag(dcache_req, 1'b0, "dcache_req in retry cycle");
            rphase = 2;
        end else if (rst_n && rphase == 2) begin
            check_flag(dcache_req, 1'b1, "dcache_req after retry");
            check_addr(dcache_addr, to_addr, "reissue");
            check_word(dcache_wdata, to_data, "reissue");
            check_sel(dcache_sel, to_sel, "reissue");
            rphase = 0;
        end
        if (rst_n && stb_timeout) begin
            n_timeouts++;
            to_addr = dcache_addr;
            to_data = dcache_wdata;
            to_sel  = dcache_sel;
            rphase  = 1;
        end
    end

    initial begin
        int d;
        int t;
        void'($urandom(32'h7666aaee));
        // Columns are addr, data, sel and ack delay
        // Delays 22 and 40 run past the watchdog
        tbl_addr = '{32'h0000_1000, 32'h0000_1004, 32'h0000_2008, 32'h8000_0010,
                     32'h0000_3ffc, 32'h1234_5670, 32'h0000_0040, 32'hffff_fff0};
        tbl_data = '{32'hdead_beef, 32'h0123_4567, 32'h89ab_cdef, 32'h5a5a_a5a5,
                     32'h0000_0001, 32'hcafe_f00d, 32'h7777_0000, 32'h1357_9bdf};
        tbl_sel  = '{4'hf, 4'h3, 4'hc, 4'h1, 4'hf, 4'h8, 4'h6, 4'hf};
        tbl_delay = '{2, 5, 0, 22, 7, 40, 1, 9};
        rst_n = 1'b0;
        lsu_st_req = 1'b0;
        lsu_addr = '0;
        lsu_wdata = '0;
        lsu_sel = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag(dcache_req, 1'b0, "dcache_req after reset");
        check_flag(lsu_st_ack, 1'b0, "lsu_st_ack after reset");
        check_flag(stb_timeout, 1'b0, "stb_timeout after reset");
        check_flag(stb_empty, 1'b1, "stb_empty after reset");

        for (int i = 0; i < N_ST; i++) begin
            d = tbl_delay[i] + int'($urandom % 3);    // Ack jitter
            exp_timeouts += d / ACK_TIMEOUT;
            @(posedge clk);
            cur_delay <= d;
            store_id <= i + 1;
            lsu_st_req <= 1'b1;
            lsu_addr <= tbl_addr[i];
            lsu_wdata <= tbl_data[i];
            lsu_sel <= tbl_sel[i];
            t = 0;
            do begin                                  // Bypass shows up first
                @(negedge clk);
                t++;
            end while (!dcache_req && t < WAIT_MAX);
            if (!dcache_req) begin
                $display("Store %0d never reached the cache port", i);
                wait_errs++;
            end
            check_flag(lsu_st_ack, 1'b0, "lsu_st_ack at bypass start");
            check_addr(dcache_addr, tbl_addr[i], "bypass");
            check_word(dcache_wdata, tbl_data[i], "bypass");
            check_sel(dcache_sel, tbl_sel[i], "bypass");
            t = 0;
            while (!lsu_st_ack && t < WAIT_MAX) begin
                @(negedge clk);
                t++;
            end
            if (!lsu_st_ack) begin
                $display("Store %0d was never acknowledged to the LSU", i);
                wait_errs++;
            end else begin
                check_flag(dcache_ack, 1'b1, "dcache_ack with lsu_st_ack");
            end
            @(posedge clk);
            lsu_st_req <= 1'b0;
        end

        repeat (3) @(negedge clk);
        check_flag(stb_empty, 1'b1, "stb_empty at end");
        if (n_timeouts != exp_timeouts)
            report_fail($sformatf("%0d timeouts, expected %0d", n_timeouts, exp_timeouts));
        if (obs_addr.size() != N_ST)
            report_fail($sformatf("%0d cache writes, expected %0d", obs_addr.size(), N_ST));
        for (int i = 0; i < N_ST && i < obs_addr.size(); i++) begin
            check_addr(obs_addr[i], tbl_addr[i], "cache write");
            check_word(obs_data[i], tbl_data[i], "cache write");
            check_sel(obs_sel[i], tbl_sel[i], "cache write");
        end

        $display("Errors: %0d wrong values, %0d wait timeouts", val_errs, wait_errs);
        if (val_errs == 0 && wait_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
design/stb_geom_pkg.sv
design/stb_ctrl_pkg.sv
design/stb_datapath.sv
design/stb_ack_timer.sv
design/stb_drain_fsm.sv
design/store_buffer_top.sv
verif/store_buffer_assert.sv
verif/store_buffer_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the store buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module store_buffer_tb \
    -f project.f \
    -o sim_store_buffer

output=$(./obj_dir/sim_store_buffer)
echo "$output"

if echo "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
else
    exit 1
fi
